// File: hw/key_extract_settings.svh
`ifndef KEY_EXTRACT_SETTINGS_SVH
`define KEY_EXTRACT_SETTINGS_SVH

// container widths and counts
`define W6B 48
`define W4B 32
`define W2B 16
`define N_CONT 8

// metadata and comparators
`define META_W 356
`define CMP_W 20
`define N_CMP 5

// key and offset entries
`define KEY_W 101
`define OFF_W 9

// tenant tables
`define TBL_DEPTH 16
`define TBL_AW 4

// control stream
`define CTRL_W 256
`define CTRL_FLAG 16'hf2f1
`define EXTRACTOR_ID 1

`endif

// File: hw/key_extract_pkg.sv
`include "key_extract_settings.svh"

package key_extract_pkg;

    typedef enum logic [1:0] {
        T2B   = 2'b00,
        T4B   = 2'b01,
        T6B   = 2'b10,
        TNONE = 2'b11
    } cont_type_e;

    typedef enum logic [1:0] {
        GT     = 2'b00,
        GE     = 2'b01,
        EQ     = 2'b10,
        ALWAYS = 2'b11
    } cmp_op_e;

    typedef enum logic [1:0] {
        IDLE,
        WR_OFF,
        WR_MASK
    } cfg_state_e;

    // container reference view of an 8-bit operand
    typedef struct packed {
        logic [2:0] pad;
        cont_type_e ctype;
        logic [2:0] idx;
    } cmp_sel_t;

    typedef struct packed {
        cmp_op_e    op;
        logic       a_imm;
        logic [7:0] a_val;
        logic       b_imm;
        logic [7:0] b_val;
    } cmp_word_t;

    // vlan sits at metadata bits 140:129
    typedef struct packed {
        cmp_word_t [0:`N_CMP-1]                 cmp;
        logic [`META_W-`N_CMP*`CMP_W-142:0]     pad_hi;
        logic [11:0]                            vlan;
        logic [128:0]                           pad_lo;
    } meta_t;

    typedef struct packed {
        logic [`N_CONT-1:0][`W6B-1:0] c6;
        logic [`N_CONT-1:0][`W4B-1:0] c4;
        logic [`N_CONT-1:0][`W2B-1:0] c2;
        meta_t                        meta;
    } phv_t;

    typedef struct packed {
        logic [2:0] idx6;
        logic [2:0] idx4;
        logic [2:0] idx2;
    } key_off_t;

    typedef struct packed {
        logic [`W6B-1:0]   f6;
        logic [`W4B-1:0]   f4;
        logic [`W2B-1:0]   f2;
        logic [`N_CMP-1:0] cmp_bits;
    } key_t;

    typedef struct packed {
        logic [`CTRL_W-1:0] data;
        logic               last;
        logic               valid;
    } ctrl_beat_t;

    typedef struct packed {
        logic [`CTRL_W-137:0] pad_top;
        logic [7:0]           index;
        logic [3:0]           pad_sel;
        logic [3:0]           tbl_sel;
        logic [4:0]           stage;
        logic [2:0]           unit;
        logic [31:0]          pad_mid;
        logic [15:0]          flag;
        logic [63:0]          pad_low;
    } cfg_hdr_t;

    typedef struct packed {
        logic              off_en;
        logic              mask_en;
        logic [`TBL_AW-1:0] index;
        key_off_t          off_entry;
        key_t              mask_entry;
    } tbl_wr_t;

endpackage

// File: hw/cfg_parser.sv
`timescale 1ns/1ps
`include "key_extract_settings.svh"

module cfg_parser #(
    parameter int stage_id = 0
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  key_extract_pkg::ctrl_beat_t ctrl_in,
    output key_extract_pkg::ctrl_beat_t ctrl_out,
    output key_extract_pkg::tbl_wr_t    tbl_wr
);

    key_extract_pkg::cfg_state_e state;
    key_extract_pkg::cfg_hdr_t   hdr;
    logic                        hdr_match;
    // inside a packet that is not ours
    logic                        in_fwd;
    logic                        first_q;
    logic [`TBL_AW-1:0]          idx_q;
    logic                        off_en_q;
    logic                        mask_en_q;
    key_extract_pkg::key_off_t   off_q;
    key_extract_pkg::key_t       mask_q;
    logic                        out_valid_q;
    logic                        out_last_q;
    logic [`CTRL_W-1:0]          out_data_q;

    assign hdr = key_extract_pkg::cfg_hdr_t'(ctrl_in.data);
    assign hdr_match = (hdr.stage == 5'(stage_id)) &&
                       (hdr.unit == 3'(`EXTRACTOR_ID)) &&
                       (hdr.flag == `CTRL_FLAG);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= key_extract_pkg::IDLE;
            in_fwd      <= 1'b0;
            first_q     <= 1'b0;
            idx_q       <= '0;
            off_en_q    <= 1'b0;
            mask_en_q   <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            off_en_q    <= 1'b0;
            mask_en_q   <= 1'b0;
            out_valid_q <= 1'b0;
            case (state)
                key_extract_pkg::IDLE: begin
                    if (ctrl_in.valid) begin
                        if (!in_fwd && hdr_match) begin
                            // a header with last carries no entries
                            if (!ctrl_in.last) begin
                                idx_q   <= hdr.index[`TBL_AW-1:0];
                                first_q <= 1'b1;
                                state   <= (hdr.tbl_sel == 4'd0) ? key_extract_pkg::WR_OFF
                                                                 : key_extract_pkg::WR_MASK;
                            end
                        end else begin
                            out_valid_q <= 1'b1;
                            in_fwd      <= !ctrl_in.last;
                        end
                    end
                end
                key_extract_pkg::WR_OFF, key_extract_pkg::WR_MASK: begin
                    if (ctrl_in.valid) begin
                        off_en_q  <= (state == key_extract_pkg::WR_OFF);
                        mask_en_q <= (state == key_extract_pkg::WR_MASK);
                        first_q   <= 1'b0;
                        if (!first_q) begin
                            idx_q <= idx_q + 1'b1;
                        end
                        if (ctrl_in.last) begin
                            state <= key_extract_pkg::IDLE;
                        end
                    end
                end
                default: begin
                    state <= key_extract_pkg::IDLE;
                end
            endcase
        end
    end

    // beat payload and table entries, taken from the top of the beat
    always_ff @(posedge clk) begin
        if (ctrl_in.valid) begin
            out_data_q <= ctrl_in.data;
            out_last_q <= ctrl_in.last;
            off_q      <= key_extract_pkg::key_off_t'(ctrl_in.data[`CTRL_W-1 -: `OFF_W]);
            mask_q     <= key_extract_pkg::key_t'(ctrl_in.data[`CTRL_W-1 -: `KEY_W]);
        end
    end

    assign ctrl_out = '{data: out_data_q, last: out_last_q, valid: out_valid_q};

    assign tbl_wr = '{off_en:     off_en_q,
                      mask_en:    mask_en_q,
                      index:      idx_q,
                      off_entry:  off_q,
                      mask_entry: mask_q};

endmodule

// File: hw/tenant_table.sv
`timescale 1ns/1ps
`include "key_extract_settings.svh"

module tenant_table #(
    parameter int width = 9
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  logic [`TBL_AW-1:0] wr_addr,
    input  logic [width-1:0]   wr_data,
    input  logic [`TBL_AW-1:0] rd_addr,
    output logic [width-1:0]   rd_data
);

    logic [width-1:0] mem [`TBL_DEPTH];

    // tables start out all zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `TBL_DEPTH; i++) begin
                mem[i] <= '0;
            end
            rd_data <= '0;
        end else begin
            if (wr_en) begin
                mem[wr_addr] <= wr_data;
            end
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: hw/cmp_eval.sv
`timescale 1ns/1ps

module cmp_eval (
    input  logic                       clk,
    input  logic                       rst_n,
    input  key_extract_pkg::cmp_word_t cmp,
    input  key_extract_pkg::phv_t      phv,
    input  logic                       valid_in,
    output logic                       result
);

    logic [7:0]               opnd_a;
    logic [7:0]               opnd_b;
    key_extract_pkg::cmp_op_e op_q;

    // immediate, or low byte of the named container
    function automatic logic [7:0] pick(input logic imm, input logic [7:0] val,
                                        input key_extract_pkg::phv_t p);
        key_extract_pkg::cmp_sel_t sel;
        sel = key_extract_pkg::cmp_sel_t'(val);
        if (imm) begin
            return val;
        end
        case (sel.ctype)
            key_extract_pkg::T6B: return p.c6[sel.idx][7:0];
            key_extract_pkg::T4B: return p.c4[sel.idx][7:0];
            key_extract_pkg::T2B: return p.c2[sel.idx][7:0];
            default:              return 8'h00;
        endcase
    endfunction

    // stage 2
    always_ff @(posedge clk) begin
        opnd_a <= pick(cmp.a_imm, cmp.a_val, phv);
        opnd_b <= pick(cmp.b_imm, cmp.b_val, phv);
        op_q   <= cmp.op;
    end

    // stage 3, zero on idle cycles so the key stays clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= 1'b0;
        end else if (!valid_in) begin
            result <= 1'b0;
        end else begin
            case (op_q)
                key_extract_pkg::GT: result <= (opnd_a > opnd_b);
                key_extract_pkg::GE: result <= (opnd_a >= opnd_b);
                key_extract_pkg::EQ: result <= (opnd_a == opnd_b);
                default:             result <= 1'b1;
            endcase
        end
    end

endmodule

// File: hw/key_extract_pipe.sv
`timescale 1ns/1ps
`include "key_extract_settings.svh"

module key_extract_pipe #(
    parameter int stage_id = 0
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  key_extract_pkg::phv_t     phv_in,
    input  logic                      phv_valid_in,
    output logic [`TBL_AW-1:0]        tenant,
    input  key_extract_pkg::key_off_t off_entry,
    input  key_extract_pkg::key_t     mask_entry,
    output key_extract_pkg::phv_t     phv_out,
    output logic                      phv_valid_out,
    output key_extract_pkg::key_t     key_out,
    output logic                      key_valid_out,
    output key_extract_pkg::key_t     key_mask_out
);

    // this stage's bit in cmp_bits
    localparam int cmp_pos = `N_CMP - 1 - stage_id;

    key_extract_pkg::phv_t phv1;
    key_extract_pkg::phv_t phv2;
    key_extract_pkg::phv_t phv3;
    logic                  v1;
    logic                  v2;
    logic                  v3;
    logic [`W6B-1:0]       sel6;
    logic [`W4B-1:0]       sel4;
    logic [`W2B-1:0]       sel2;
    key_extract_pkg::key_t mask2;
    key_extract_pkg::key_t mask3;
    key_extract_pkg::key_t key_q;
    logic                  cmp_bit;

    // tables are read in parallel with stage 1
    assign tenant = phv_in.meta.vlan[7:4];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
        end else begin
            v1 <= phv_valid_in;
            v2 <= v1;
            v3 <= v2;
        end
    end

    always_ff @(posedge clk) begin
        phv1  <= phv_in;
        phv2  <= phv1;
        phv3  <= phv2;
        // stage 2 container select
        sel6  <= phv1.c6[off_entry.idx6];
        sel4  <= phv1.c4[off_entry.idx4];
        sel2  <= phv1.c2[off_entry.idx2];
        mask2 <= mask_entry;
        mask3 <= mask2;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_q <= '0;
        end else if (v2) begin
            key_q <= '{f6: sel6, f4: sel4, f2: sel2, cmp_bits: '0};
        end else begin
            key_q <= '0;
        end
    end

    cmp_eval u_cmp (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmp      (phv1.meta.cmp[stage_id]),
        .phv      (phv1),
        .valid_in (v2),
        .result   (cmp_bit)
    );

    // comparator bit lands with stage 3
    always_comb begin
        key_out                   = key_q;
        key_out.cmp_bits[cmp_pos] = cmp_bit;
    end

    assign phv_out       = phv3;
    assign phv_valid_out = v3;
    assign key_valid_out = v3;
    assign key_mask_out  = mask3;

endmodule

// File: hw/key_extract_top.sv
`timescale 1ns/1ps
`include "key_extract_settings.svh"

module key_extract_top #(
    parameter int stage_id = 0
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  key_extract_pkg::phv_t         phv_in,
    input  logic                          phv_valid_in,
    input  key_extract_pkg::ctrl_beat_t   ctrl_in,
    output key_extract_pkg::phv_t         phv_out,
    output logic                          phv_valid_out,
    output key_extract_pkg::key_t         key_out,
    output logic                          key_valid_out,
    output key_extract_pkg::key_t         key_mask_out,
    output key_extract_pkg::ctrl_beat_t   ctrl_out
);

    key_extract_pkg::tbl_wr_t  tbl_wr;
    key_extract_pkg::key_off_t off_entry;
    key_extract_pkg::key_t     mask_entry;
    logic [`TBL_AW-1:0]        tenant;

    cfg_parser #(.stage_id(stage_id)) u_parser (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl_in  (ctrl_in),
        .ctrl_out (ctrl_out),
        .tbl_wr   (tbl_wr)
    );

    // per-tenant container offsets
    tenant_table #(.width(`OFF_W)) off_table (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (tbl_wr.off_en),
        .wr_addr (tbl_wr.index),
        .wr_data (tbl_wr.off_entry),
        .rd_addr (tenant),
        .rd_data (off_entry)
    );

    // per-tenant key masks
    tenant_table #(.width(`KEY_W)) mask_table (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (tbl_wr.mask_en),
        .wr_addr (tbl_wr.index),
        .wr_data (tbl_wr.mask_entry),
        .rd_addr (tenant),
        .rd_data (mask_entry)
    );

    key_extract_pipe #(.stage_id(stage_id)) u_pipe (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_in        (phv_in),
        .phv_valid_in  (phv_valid_in),
        .tenant        (tenant),
        .off_entry     (off_entry),
        .mask_entry    (mask_entry),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .key_out       (key_out),
        .key_valid_out (key_valid_out),
        .key_mask_out  (key_mask_out)
    );

endmodule

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // release on a falling edge, away from the flops
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: sim/tb_key_extract.sv
`timescale 1ns/1ps
`include "key_extract_settings.svh"

module tb_key_extract;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 16;
    localparam int stage_id     = 2;
    localparam int vw           = 1200;
    localparam int phv_w        = $bits(key_extract_pkg::phv_t);
    localparam int n_cfg_a      = 14;
    localparam int n_cfg_b      = 10;
    localparam int n_phv        = 400;
    // header, eight data beats with gaps, four idle cycles
    localparam int pkt_max      = 21;
    localparam longint wd_cycles = reset_cycles + 2 + (n_cfg_a + n_cfg_b) * pkt_max
                                   + 2 * (n_phv * 2 + 4) + 200;

    logic                        clk;
    logic                        rst_n;
    key_extract_pkg::phv_t       phv_in;
    logic                        phv_valid_in;
    key_extract_pkg::ctrl_beat_t ctrl_in;
    key_extract_pkg::phv_t       phv_out;
    logic                        phv_valid_out;
    key_extract_pkg::key_t       key_out;
    logic                        key_valid_out;
    key_extract_pkg::key_t       key_mask_out;
    key_extract_pkg::ctrl_beat_t ctrl_out;

    logic [15:0]                 lfsr;
    int                          n_checks;
    int                          n_errors;

    // reference tables
    logic [`OFF_W-1:0]           off_tbl [`TBL_DEPTH];
    logic [`KEY_W-1:0]           mask_tbl [`TBL_DEPTH];

    // expected outputs in arrival order
    logic                        exp_pv_q [$];
    key_extract_pkg::phv_t       exp_phv_q [$];
    logic [`KEY_W-1:0]           exp_key_q [$];
    logic [`KEY_W-1:0]           exp_mask_q [$];
    logic                        exp_cv_q [$];
    logic [`CTRL_W:0]            exp_cd_q [$];

    tb_clk_gen #(.period_ns(clk_period), .reset_cycles(reset_cycles)) u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    key_extract_top #(.stage_id(stage_id)) dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .phv_in        (phv_in),
        .phv_valid_in  (phv_valid_in),
        .ctrl_in       (ctrl_in),
        .phv_out       (phv_out),
        .phv_valid_out (phv_valid_out),
        .key_out       (key_out),
        .key_valid_out (key_valid_out),
        .key_mask_out  (key_mask_out),
        .ctrl_out      (ctrl_out)
    );

    // galois lfsr stepped once per bit
    function automatic logic next_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic logic [vw-1:0] rand_bits(input int n);
        logic [vw-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = next_bit();
        end
        return v;
    endfunction

    function automatic int rand_small(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(next_bit());
        end
        return v;
    endfunction

    function automatic logic [7:0] cmp_operand(input logic imm, input logic [7:0] val,
                                               input key_extract_pkg::phv_t p);
        if (imm) begin
            return val;
        end
        case (val[4:3])
            2'b00:   return p.c2[val[2:0]][7:0];
            2'b01:   return p.c4[val[2:0]][7:0];
            2'b10:   return p.c6[val[2:0]][7:0];
            default: return 8'h00;
        endcase
    endfunction

    // op, a_imm, a_val, b_imm, b_val from the top
    function automatic logic comparison(input logic [`CMP_W-1:0] w,
                                        input key_extract_pkg::phv_t p);
        logic [7:0] a;
        logic [7:0] b;
        a = cmp_operand(w[17], w[16:9], p);
        b = cmp_operand(w[8], w[7:0], p);
        case (w[19:18])
            2'b00:   return a > b;
            2'b01:   return a >= b;
            2'b10:   return a == b;
            default: return 1'b1;
        endcase
    endfunction

    task automatic compare(input string name, input logic [vw-1:0] exp,
                           input logic [vw-1:0] act);
        n_checks++;
        assert (act === exp) else begin
            $display("Fail %0t %s expected %0h got %0h", $time, name, exp, act);
            n_errors++;
        end
    endtask

    task automatic check_outputs();
        logic                  e_pv;
        key_extract_pkg::phv_t e_phv;
        logic [`KEY_W-1:0]     e_key;
        logic [`KEY_W-1:0]     e_mask;
        logic                  e_cv;
        logic [`CTRL_W:0]      e_cd;
        e_pv   = exp_pv_q.pop_front();
        e_phv  = exp_phv_q.pop_front();
        e_key  = exp_key_q.pop_front();
        e_mask = exp_mask_q.pop_front();
        e_cv   = exp_cv_q.pop_front();
        e_cd   = exp_cd_q.pop_front();
        compare("phv_valid_out", vw'(e_pv), vw'(phv_valid_out));
        compare("key_valid_out", vw'(e_pv), vw'(key_valid_out));
        if (e_pv) begin
            compare("phv_out", vw'(e_phv), vw'(phv_out));
            compare("key_out", vw'(e_key), vw'(key_out));
            compare("key_mask_out", vw'(e_mask), vw'(key_mask_out));
        end else begin
            compare("key_out", '0, vw'(key_out));
        end
        compare("ctrl_out.valid", vw'(e_cv), vw'(ctrl_out.valid));
        if (e_cv) begin
            compare("ctrl_out.data", vw'(e_cd[`CTRL_W:1]), vw'(ctrl_out.data));
            compare("ctrl_out.last", vw'(e_cd[0]), vw'(ctrl_out.last));
        end
    endtask

    // check what came out and drive the next inputs on a falling edge
    task automatic step(input key_extract_pkg::phv_t p, input logic pv,
                        input logic [`CTRL_W-1:0] cd, input logic cl,
                        input logic cv, input logic fwd);
        logic [3:0]        tenant;
        logic [`OFF_W-1:0] off;
        logic [`KEY_W-1:0] key;
        @(negedge clk);
        check_outputs();
        phv_in        = p;
        phv_valid_in  = pv;
        ctrl_in.data  = cd;
        ctrl_in.last  = cl;
        ctrl_in.valid = cv;
        tenant = p.meta.vlan[7:4];
        off    = off_tbl[tenant];
        key    = {p.c6[off[8:6]], p.c4[off[5:3]], p.c2[off[2:0]], 5'b0};
        key[4 - stage_id] = comparison(p.meta.cmp[stage_id], p);
        exp_pv_q.push_back(pv);
        exp_phv_q.push_back(p);
        exp_key_q.push_back(key);
        exp_mask_q.push_back(mask_tbl[tenant]);
        exp_cv_q.push_back(cv && fwd);
        exp_cd_q.push_back({cd, cl});
    endtask

    task automatic idle_step();
        step('0, 1'b0, '0, 1'b0, 1'b0, 1'b0);
    endtask

    // kind 0 offset table, 1 mask table, 2 foreign packet
    task automatic send_cfg(input int kind, input int n_data, input logic [3:0] base);
        logic [vw-1:0]      r;
        logic [`CTRL_W-1:0] hdr;
        logic [`CTRL_W-1:0] beat;
        logic [3:0]         idx;
        logic               fwd;
        r   = rand_bits(`CTRL_W);
        hdr = r[`CTRL_W-1:0];
        hdr[119:115] = 5'(stage_id);
        hdr[114:112] = 3'(`EXTRACTOR_ID);
        hdr[79:64]   = `CTRL_FLAG;
        hdr[131:128] = base;
        hdr[123:120] = (kind == 0) ? 4'd0 : 4'(rand_small(4));
        if (kind == 1 && hdr[123:120] == 4'd0) begin
            hdr[123:120] = 4'd9;
        end
        fwd = (kind == 2);
        if (fwd) begin
            // break exactly one of the match fields
            case (rand_small(2) % 3)
                0: begin
                    hdr[119:115] = 5'(rand_small(5));
                    if (hdr[119:115] == 5'(stage_id)) hdr[119:115] = hdr[119:115] ^ 5'd1;
                end
                1: begin
                    hdr[114:112] = 3'(rand_small(3));
                    if (hdr[114:112] == 3'(`EXTRACTOR_ID)) hdr[114:112] = hdr[114:112] ^ 3'd4;
                end
                default: begin
                    hdr[79:64] = 16'(rand_small(16));
                    if (hdr[79:64] == `CTRL_FLAG) hdr[79:64] = hdr[79:64] ^ 16'd1;
                end
            endcase
        end
        step('0, 1'b0, hdr, n_data == 0, 1'b1, fwd);
        idx = base;
        for (int i = 0; i < n_data; i++) begin
            if (rand_small(2) == 0) begin
                r = rand_bits(`CTRL_W + 1);
                step('0, 1'b0, r[`CTRL_W-1:0], r[`CTRL_W], 1'b0, fwd);
            end
            r    = rand_bits(`CTRL_W);
            beat = r[`CTRL_W-1:0];
            step('0, 1'b0, beat, i == n_data - 1, 1'b1, fwd);
            if (!fwd) begin
                if (kind == 0) begin
                    off_tbl[idx] = beat[`CTRL_W-1 -: `OFF_W];
                end else begin
                    mask_tbl[idx] = beat[`CTRL_W-1 -: `KEY_W];
                end
                idx = idx + 4'd1;
            end
        end
        repeat (4) idle_step();
    endtask

    task automatic run_phv(input int n);
        logic [vw-1:0]          r;
        logic [`CMP_W-1:0]      w;
        key_extract_pkg::phv_t  p;
        for (int i = 0; i < n; i++) begin
            if (rand_small(2) == 0) begin
                idle_step();
            end
            r = rand_bits(phv_w);
            p = key_extract_pkg::phv_t'(r[phv_w-1:0]);
            // sometimes make both operands identical so EQ can hit
            if (rand_small(2) == 0) begin
                w = p.meta.cmp[stage_id];
                w[8:0] = w[17:9];
                p.meta.cmp[stage_id] = key_extract_pkg::cmp_word_t'(w);
            end
            step(p, 1'b1, '0, 1'b0, 1'b0, 1'b0);
        end
    endtask

    initial begin
        logic [3:0] base;
        lfsr         = 16'd29585;
        n_checks     = 0;
        n_errors     = 0;
        phv_in       = '0;
        phv_valid_in = 1'b0;
        ctrl_in      = '0;
        for (int i = 0; i < `TBL_DEPTH; i++) begin
            off_tbl[i]  = '0;
            mask_tbl[i] = '0;
        end
        // the pipeline holds three phvs and the control path holds one beat
        repeat (3) begin
            exp_pv_q.push_back(1'b0);
            exp_phv_q.push_back('0);
            exp_key_q.push_back('0);
            exp_mask_q.push_back('0);
        end
        exp_cv_q.push_back(1'b0);
        exp_cd_q.push_back('0);

        repeat (reset_cycles + 2) idle_step();

        // fill every tenant with start points that make the writes wrap
        base = 4'(rand_small(4));
        send_cfg(0, 8, base);
        send_cfg(0, 8, base + 4'd8);
        send_cfg(1, 8, base + 4'd3);
        send_cfg(1, 8, base + 4'd11);
        repeat (n_cfg_a - 4) send_cfg(rand_small(2) % 3, rand_small(3), 4'(rand_small(4)));
        run_phv(n_phv);
        repeat (4) idle_step();

        repeat (n_cfg_b) send_cfg(rand_small(2) % 3, rand_small(3), 4'(rand_small(4)));
        run_phv(n_phv);
        repeat (4) idle_step();

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(wd_cycles * clk_period);
        $display("watchdog expired before the test sequence finished");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: build.f
+incdir+hw
hw/key_extract_pkg.sv
hw/cfg_parser.sv
hw/tenant_table.sv
hw/cmp_eval.sv
hw/key_extract_pipe.sv
hw/key_extract_top.sv
sim/tb_clk_gen.sv
sim/tb_key_extract.sv
